/* include/rv32_fields.svh */
`ifndef rv32_fields_svh
`define rv32_fields_svh

////////////////////////////////////////////////////////////////////////////
// RV32 instruction word fields
////////////////////////////////////////////////////////////////////////////

// Argument must be a plain signal name, since part-selects follow it
`define rv32_opcode(inst) inst[6:0]
`define rv32_funct3(inst) inst[14:12]
`define rv32_funct7(inst) inst[31:25]
`define rv32_rd(inst)     inst[11:7]

////////////////////////////////////////////////////////////////////////////
// Immediates, all sign extended to 32 bits
////////////////////////////////////////////////////////////////////////////

`define rv32_imm_i(inst) {{20{inst[31]}}, inst[31:20]}
`define rv32_imm_u(inst) {inst[31:12], 12'b0}                  // Low 12 bits zero
`define rv32_imm_j(inst) {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}
`define rv32_imm_b(inst) {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}

`endif

/* list.f */
+incdir+include
source/ex_pkg.sv
source/alu.sv
source/decode_stage.sv
source/pipe_fifo.sv
source/stage_ex.sv
source/ex_top.sv
verif/tb_ex_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run tb_ex_top with Verilator; the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ex_top -f list.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [ex_pkg::xlen-1:0] opa,
    input  logic [ex_pkg::xlen-1:0] opb,
    input  ex_pkg::alu_func_t       func,
    output logic [ex_pkg::xlen-1:0] result
);
    import ex_pkg::*;

    logic signed [xlen-1:0]   signed_opa;
    logic signed [xlen-1:0]   signed_opb;
    logic signed [2*xlen-1:0] opa_sext;
    logic signed [2*xlen-1:0] opb_sext;
    logic signed [2*xlen-1:0] opb_zext;     // Non-negative as signed
    logic signed [2*xlen-1:0] signed_mul;
    logic signed [2*xlen-1:0] mixed_mul;
    logic        [2*xlen-1:0] unsigned_mul;
    logic        [4:0]        shamt;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt      = opb[4:0];          // Shift amount

    // 64-bit products
    assign opa_sext     = {{xlen{opa[xlen-1]}}, opa};
    assign opb_sext     = {{xlen{opb[xlen-1]}}, opb};
    assign opb_zext     = {{xlen{1'b0}}, opb};
    assign signed_mul   = opa_sext * opb_sext;
    assign mixed_mul    = opa_sext * opb_zext;
    assign unsigned_mul = {{xlen{1'b0}}, opa} * {{xlen{1'b0}}, opb};

    always_comb begin
        case (func)
            alu_add:    result = opa + opb;
            alu_sub:    result = opa - opb;
            alu_and:    result = opa & opb;
            alu_or:     result = opa | opb;
            alu_xor:    result = opa ^ opb;
            alu_slt:    result = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
            alu_sltu:   result = {{(xlen-1){1'b0}}, opa < opb};
            alu_sll:    result = opa << shamt;
            alu_srl:    result = opa >> shamt;
            alu_sra:    result = signed_opa >>> shamt;      // Sign fill
            alu_mul:    result = signed_mul[xlen-1:0];      // Low half, same for all signs
            alu_mulh:   result = signed_mul[2*xlen-1:xlen];
            alu_mulhsu: result = mixed_mul[2*xlen-1:xlen];
            alu_mulhu:  result = unsigned_mul[2*xlen-1:xlen];
            default:    result = '0;                        // Two unused codes
        endcase
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/10ps
`include "rv32_fields.svh"

module decode_stage (
    input  logic [ex_pkg::xlen-1:0] inst,
    input  logic [ex_pkg::xlen-1:0] pc,
    input  logic [ex_pkg::xlen-1:0] rs1_value,
    input  logic [ex_pkg::xlen-1:0] rs2_value,
    input  logic                    valid_in,
    output logic                    ready_in,
    output logic                    valid_out,
    input  logic                    ready_out,
    output ex_pkg::id_ex_packet_t   packet
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad_inst;     // Unsupported opcode or funct combination

    // Shared funct3 table of OP and OP-IMM, alt picks sub/sra
    function automatic alu_func_t base_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = `rv32_opcode(inst);
    assign funct3 = `rv32_funct3(inst);
    assign funct7 = `rv32_funct7(inst);

    assign valid_out = valid_in;      // Combinational stage
    assign ready_in  = ready_out;

    always_comb begin
        bad_inst             = 1'b0;
        packet.pc            = pc;
        packet.npc           = pc + 32'd4;
        packet.rs1_value     = rs1_value;
        packet.rs2_value     = rs2_value;
        packet.imm           = '0;
        packet.opa_select    = opa_is_rs1;
        packet.opb_select    = opb_is_rs2;
        packet.alu_func      = alu_add;
        packet.br_funct3     = funct3;
        packet.cond_branch   = 1'b0;
        packet.uncond_branch = 1'b0;
        packet.dest_reg_idx  = `rv32_rd(inst);
        packet.illegal       = 1'b0;

        case (opcode)
            op_reg: begin
                if (funct7 == 7'b0000001) begin               // M extension
                    bad_inst = funct3[2];                     // Divides not supported
                    case (funct3[1:0])
                        2'b00:   packet.alu_func = alu_mul;
                        2'b01:   packet.alu_func = alu_mulh;
                        2'b10:   packet.alu_func = alu_mulhsu;
                        default: packet.alu_func = alu_mulhu;
                    endcase
                end else if (funct7 == 7'b0000000) begin
                    packet.alu_func = base_func(funct3, 1'b0);
                end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    packet.alu_func = base_func(funct3, 1'b1);  // sub, sra
                end else begin
                    bad_inst = 1'b1;
                end
            end
            op_imm: begin
                packet.opb_select = opb_is_imm;
                packet.imm        = `rv32_imm_i(inst);
                packet.alu_func   = base_func(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) bad_inst = (funct7 != 7'b0000000);       // slli
                if (funct3 == 3'b101) bad_inst = (funct7 != 7'b0000000) &&
                                                 (funct7 != 7'b0100000);       // srli, srai
            end
            op_lui: begin
                packet.opa_select = opa_is_zero;
                packet.opb_select = opb_is_imm;
                packet.imm        = `rv32_imm_u(inst);
            end
            op_auipc: begin
                packet.opa_select = opa_is_pc;
                packet.opb_select = opb_is_imm;
                packet.imm        = `rv32_imm_u(inst);
            end
            op_jal, op_jalr: begin
                // Link value is npc + 0, rs2 is unused by jumps
                packet.opa_select    = opa_is_npc;
                packet.rs2_value     = '0;
                packet.uncond_branch = 1'b1;
                packet.imm = (opcode == op_jal) ? `rv32_imm_j(inst) : `rv32_imm_i(inst);
                if (opcode == op_jalr) bad_inst = (funct3 != 3'b000);
            end
            op_branch: begin
                packet.opa_select   = opa_is_pc;              // Target pc + imm
                packet.opb_select   = opb_is_imm;
                packet.imm          = `rv32_imm_b(inst);
                packet.cond_branch  = 1'b1;
                packet.dest_reg_idx = 5'd0;                   // No writeback
                bad_inst = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: bad_inst = 1'b1;                         // Loads, stores, system
        endcase

        if (bad_inst) begin
            packet.illegal       = 1'b1;
            packet.alu_func      = alu_add;
            packet.opa_select    = opa_is_rs1;
            packet.opb_select    = opb_is_rs2;
            packet.cond_branch   = 1'b0;
            packet.uncond_branch = 1'b0;
            packet.dest_reg_idx  = 5'd0;
        end
    end

endmodule

/* source/ex_pkg.sv */
package ex_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths and major opcodes
    ////////////////////////////////////////////////////////////////////////

    localparam int xlen = 32;                         // Data path width

    localparam logic [6:0] op_reg    = 7'b0110011;    // OP
    localparam logic [6:0] op_imm    = 7'b0010011;    // OP-IMM
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    ////////////////////////////////////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mul,
        alu_mulh,       // Signed x signed, high half
        alu_mulhsu,     // Signed x unsigned, high half
        alu_mulhu       // Unsigned x unsigned, high half
    } alu_func_t;

    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_npc,
        opa_is_pc,
        opa_is_zero
    } opa_sel_t;

    typedef enum logic {
        opb_is_rs2,
        opb_is_imm
    } opb_sel_t;

    // Decoded instruction, decode to execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;           // pc + 4
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] imm;           // Already sign extended
        opa_sel_t        opa_select;
        opb_sel_t        opb_select;
        alu_func_t       alu_func;
        logic [2:0]      br_funct3;
        logic            cond_branch;
        logic            uncond_branch;
        logic [4:0]      dest_reg_idx;
        logic            illegal;
    } id_ex_packet_t;

    // Execute result, 71 bits
    typedef struct packed {
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] npc;
        logic            take_branch;
        logic [4:0]      dest_reg_idx;
        logic            illegal;
    } ex_result_t;

endpackage

/* source/ex_top.sv */
`timescale 1ns/10ps

module ex_top (
    input  logic                    clock,
    input  logic                    rst_n,
    // Instruction stream in
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [ex_pkg::xlen-1:0] in_inst,
    input  logic [ex_pkg::xlen-1:0] in_pc,
    input  logic [ex_pkg::xlen-1:0] in_rs1_value,
    input  logic [ex_pkg::xlen-1:0] in_rs2_value,
    // Result stream out
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [ex_pkg::xlen-1:0] out_alu_result,
    output logic [ex_pkg::xlen-1:0] out_npc,
    output logic                    out_take_branch,
    output logic [4:0]              out_dest_reg,
    output logic                    out_illegal
);
    import ex_pkg::*;

    logic          dec_valid;
    logic          dec_ready;
    id_ex_packet_t dec_packet;
    logic          iq_valid;
    logic          iq_ready;
    id_ex_packet_t iq_packet;
    logic          ex_valid;
    logic          ex_ready;
    ex_result_t    ex_result;
    ex_result_t    out_result;

    decode_stage decode_0 (
        .inst (in_inst), .pc (in_pc), .rs1_value (in_rs1_value), .rs2_value (in_rs2_value),
        .valid_in (in_valid), .ready_in (in_ready),
        .valid_out (dec_valid), .ready_out (dec_ready), .packet (dec_packet)
    );

    pipe_fifo #(.payload_t(id_ex_packet_t)) iq_fifo (   // Decoded packet queue
        .clock (clock), .rst_n (rst_n),
        .in_valid (dec_valid), .in_ready (dec_ready), .in_data (dec_packet),
        .out_valid (iq_valid), .out_ready (iq_ready), .out_data (iq_packet)
    );

    stage_ex ex_0 (
        .valid_in (iq_valid), .ready_in (iq_ready), .packet (iq_packet),
        .valid_out (ex_valid), .ready_out (ex_ready), .result (ex_result)
    );

    pipe_fifo #(.payload_t(ex_result_t)) out_fifo (     // Result buffer
        .clock (clock), .rst_n (rst_n),
        .in_valid (ex_valid), .in_ready (ex_ready), .in_data (ex_result),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_result)
    );

    // Unpack head of result queue
    assign out_alu_result  = out_result.alu_result;
    assign out_npc         = out_result.npc;
    assign out_take_branch = out_result.take_branch;
    assign out_dest_reg    = out_result.dest_reg_idx;
    assign out_illegal     = out_result.illegal;

endmodule

/* source/pipe_fifo.sv */
`timescale 1ns/10ps

module pipe_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   slots [2];      // Two entry storage
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;          // 0, 1 or 2 entries
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);     // Independent of pop
    assign out_valid = (count != 2'd0);
    assign out_data  = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) slots[wr_ptr] <= in_data;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;    // Idle or push with pop
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    count_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        count <= 2'd2);

    // Stalled head stays put until the consumer takes it
    head_held: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* source/stage_ex.sv */
`timescale 1ns/10ps

module stage_ex (
    input  logic                  valid_in,
    output logic                  ready_in,
    input  ex_pkg::id_ex_packet_t packet,
    output logic                  valid_out,
    input  logic                  ready_out,
    output ex_pkg::ex_result_t    result
);
    import ex_pkg::*;

    logic        [xlen-1:0] opa_mux;
    logic        [xlen-1:0] opb_mux;
    logic        [xlen-1:0] alu_out;
    logic signed [xlen-1:0] rs1_signed;
    logic signed [xlen-1:0] rs2_signed;
    logic                   br_cond;       // Condition of a conditional branch

    assign valid_out = valid_in;           // No state here
    assign ready_in  = ready_out;

    ////////////////////////////////////////////////////////////////////////////
    // Operand muxes and ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (packet.opa_select)
            opa_is_rs1: opa_mux = packet.rs1_value;
            opa_is_npc: opa_mux = packet.npc;
            opa_is_pc:  opa_mux = packet.pc;
            default:    opa_mux = '0;
        endcase
    end

    assign opb_mux = (packet.opb_select == opb_is_imm) ? packet.imm : packet.rs2_value;

    alu alu_0 (
        .opa    (opa_mux),
        .opb    (opb_mux),
        .func   (packet.alu_func),
        .result (alu_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////////////////////////////////////////

    assign rs1_signed = packet.rs1_value;
    assign rs2_signed = packet.rs2_value;

    always_comb begin
        case (packet.br_funct3)
            3'b000:  br_cond = packet.rs1_value == packet.rs2_value;   // beq
            3'b001:  br_cond = packet.rs1_value != packet.rs2_value;   // bne
            3'b100:  br_cond = rs1_signed <  rs2_signed;               // blt
            3'b101:  br_cond = rs1_signed >= rs2_signed;               // bge
            3'b110:  br_cond = packet.rs1_value <  packet.rs2_value;   // bltu
            3'b111:  br_cond = packet.rs1_value >= packet.rs2_value;   // bgeu
            default: br_cond = 1'b0;
        endcase
    end

    // Result packet
    assign result.alu_result   = alu_out;
    assign result.npc          = packet.npc;
    assign result.take_branch  = packet.uncond_branch || (packet.cond_branch && br_cond);
    assign result.dest_reg_idx = packet.dest_reg_idx;
    assign result.illegal      = packet.illegal;

endmodule

/* verif/tb_ex_top.sv */
`timescale 1ns/10ps
`include "rv32_fields.svh"

module tb_ex_top;
    import ex_pkg::*;

    localparam int n_alu     = 48;
    localparam int n_mul     = 32;
    localparam int n_upper   = 24;
    localparam int n_branch  = 36;      // Six conditions with six pairs each
    localparam int n_stress  = 60;
    localparam int n_illegal = 12;
    localparam int n_total   = n_alu + n_mul + n_upper + n_branch + n_stress + n_illegal;
    localparam int timeout_cycles = 8 * n_total + 100;

    logic        clock;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic [31:0] in_rs1_value;
    logic [31:0] in_rs2_value;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_alu_result;
    logic [31:0] out_npc;
    logic        out_take_branch;
    logic [4:0]  out_dest_reg;
    logic        out_illegal;

    logic [70:0] out_word;              // Outputs packed like ex_result_t
    ex_result_t  exp_queue [$];         // Expected results in order
    ex_result_t  exp_head;
    logic        exp_pending;
    logic        reset_window;          // Reset plus first cycle after
    logic        random_ready;          // Back-pressure on out_ready
    logic [31:0] lfsr_state = 32'd89263;
    string       test_name = "reset";
    int          error_count = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    ex_top uut (
        .clock (clock), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_inst (in_inst), .in_pc (in_pc),
        .in_rs1_value (in_rs1_value), .in_rs2_value (in_rs2_value),
        .out_valid (out_valid), .out_ready (out_ready), .out_alu_result (out_alu_result),
        .out_npc (out_npc), .out_take_branch (out_take_branch), .out_dest_reg (out_dest_reg),
        .out_illegal (out_illegal)
    );

    assign out_word = {out_alu_result, out_npc, out_take_branch, out_dest_reg, out_illegal};

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;      // 100 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    // OP and OP-IMM funct3 table where alt selects sub or sra
    function automatic logic [31:0] base_ref(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(input logic [1:0] kind,
                                            input logic [31:0] a, input logic [31:0] b);
        longint      ss;
        longint      su;
        logic [63:0] uu;
        ss = longint'($signed(a)) * longint'($signed(b));
        su = longint'($signed(a)) * longint'({32'b0, b});   // b taken as unsigned
        uu = {32'b0, a} * {32'b0, b};
        case (kind)
            2'd0:    return ss[31:0];
            2'd1:    return ss[63:32];
            2'd2:    return su[63:32];
            default: return uu[63:32];
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic ex_result_t model_result(input logic [31:0] inst, input logic [31:0] pc,
                                                input logic [31:0] rs1, input logic [31:0] rs2);
        ex_result_t  r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        f3             = `rv32_funct3(inst);
        f7             = `rv32_funct7(inst);
        r.alu_result   = '0;
        r.npc          = pc + 32'd4;
        r.take_branch  = 1'b0;
        r.dest_reg_idx = `rv32_rd(inst);
        r.illegal      = 1'b0;
        case (`rv32_opcode(inst))
            op_reg:   r.alu_result = (f7 == 7'b0000001) ? mul_ref(f3[1:0], rs1, rs2)
                                                        : base_ref(f3, f7[5], rs1, rs2);
            op_imm:   r.alu_result = base_ref(f3, f3 == 3'b101 && f7[5], rs1, `rv32_imm_i(inst));
            op_lui:   r.alu_result = `rv32_imm_u(inst);
            op_auipc: r.alu_result = pc + `rv32_imm_u(inst);
            op_jal, op_jalr: begin
                r.alu_result  = pc + 32'd4;                  // Link value
                r.take_branch = 1'b1;
            end
            op_branch: begin
                r.alu_result   = pc + `rv32_imm_b(inst);     // Branch target
                r.take_branch  = branch_ref(f3, rs1, rs2);
                r.dest_reg_idx = 5'd0;
            end
            default: begin                                   // Flagged illegal with rs1 + rs2
                r.alu_result   = rs1 + rs2;
                r.dest_reg_idx = 5'd0;
                r.illegal      = 1'b1;
            end
        endcase
        return r;
    endfunction

    // Legal OP or OP-IMM word with random fields
    function automatic logic [31:0] alu_inst(input logic use_imm);
        logic [31:0] inst;
        logic [2:0]  f3;
        logic [6:0]  f7;
        inst = rand_bits(32);
        f3   = 3'(rand_bits(3));
        f7   = inst[31:25];
        if (use_imm) begin
            if (f3 == 3'b001) f7 = 7'b0;                     // slli
            if (f3 == 3'b101) f7 = {1'b0, f7[5], 5'b0};      // srli or srai
        end else begin
            f7 = (f7[5] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        end
        inst[31:25] = f7;
        inst[14:12] = f3;
        inst[6:0]   = use_imm ? op_imm : op_reg;
        return inst;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (out_valid && out_ready && exp_queue.size() != 0) void'(exp_queue.pop_front());
        if (in_valid && in_ready)
            exp_queue.push_back(model_result(in_inst, in_pc, in_rs1_value, in_rs2_value));
        exp_pending = (exp_queue.size() != 0);
        exp_head    = exp_pending ? exp_queue[0] : '0;
    end

    result_matches: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && out_ready && exp_pending |-> out_word == exp_head)
        else begin
            $display("** Error %s: expected %h, actual %h", test_name,
                     $sampled(exp_head), $sampled(out_word));
            error_count++;
        end

    no_extra_result: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && out_ready |-> exp_pending)
        else begin
            $display("Test %s: a result came out with no instruction outstanding", test_name);
            error_count++;
        end

    valid_held: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid)
        else begin
            $display("Test %s: out_valid dropped before its handshake", test_name);
            error_count++;
        end

    reset_state: assert property (@(posedge clock) reset_window |-> !out_valid && in_ready)
        else begin
            $display("Test reset: out_valid high or in_ready low around reset");
            error_count++;
        end

    // Watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (random_ready) out_ready = (2'(rand_bits(2)) != 2'b00);   // About 3 in 4 high
        else              out_ready = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc,
                             input logic [31:0] rs1, input logic [31:0] rs2);
        @(negedge clock);
        in_valid     = 1'b1;
        in_inst      = inst;
        in_pc        = pc;
        in_rs1_value = rs1;
        in_rs2_value = rs2;
        @(posedge clock);
        while (!in_ready) @(posedge clock);      // Held until accepted
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = error_count;
    endtask

    // Drain all results and report
    task automatic end_test;
        @(negedge clock);
        in_valid = 1'b0;
        while (exp_queue.size() != 0) @(negedge clock);
        @(posedge clock);
        random_ready = 1'b0;
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("Test %-12s passed", test_name);
        end else begin
            $display("Test %-12s failed with %0d errors", test_name,
                     error_count - test_start_errors);
            tests_failed++;
        end
    endtask

    function automatic logic [31:0] rand_pc();
        return {30'(rand_bits(30)), 2'b00};    // Word aligned
    endfunction

    initial begin
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        int          c;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        in_pc        = '0;
        in_rs1_value = '0;
        in_rs2_value = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        reset_window = 1'b1;

        start_test("reset");
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        @(posedge clock);                        // First cycle after reset
        @(negedge clock);
        reset_window = 1'b0;
        end_test();

        start_test("alu_ops");
        for (int k = 0; k < n_alu; k++) begin
            inst = alu_inst(k[0]);
            send_inst(inst, rand_pc(), rand_bits(32), rand_bits(32));
        end
        end_test();

        start_test("multiply");
        for (int k = 0; k < n_mul; k++) begin
            inst = rand_bits(32);
            inst[31:25] = 7'b0000001;
            inst[14:12] = {1'b0, k[1:0]};        // mul, mulh, mulhsu, mulhu
            inst[6:0]   = op_reg;
            a = rand_bits(32);
            b = rand_bits(32);
            a[31] = k[2] | a[31];                // Force sign bits on some
            b[31] = k[3] | b[31];
            send_inst(inst, rand_pc(), a, b);
        end
        end_test();

        start_test("upper_jump");
        for (int k = 0; k < n_upper; k++) begin
            inst = rand_bits(32);
            case (k % 4)
                0:       inst[6:0] = op_lui;
                1:       inst[6:0] = op_auipc;
                2:       inst[6:0] = op_jal;
                default: begin
                    inst[6:0]   = op_jalr;
                    inst[14:12] = 3'b000;
                end
            endcase
            send_inst(inst, rand_pc(), rand_bits(32), rand_bits(32));
        end
        end_test();

        start_test("branch");
        for (int k = 0; k < n_branch; k++) begin
            c = k / 6;
            inst = rand_bits(32);
            inst[14:12] = 3'(c < 2 ? c : c + 2); // beq bne blt bge bltu bgeu
            inst[6:0]   = op_branch;
            a = rand_bits(32);
            b = rand_bits(32);
            case (k % 3)
                0:       b = a;                               // Equal pair
                1:       if (a > b) {a, b} = {b, a};          // rs1 below rs2
                default: if (a < b) {a, b} = {b, a};          // rs1 above rs2
            endcase
            send_inst(inst, rand_pc(), a, b);
        end
        end_test();

        start_test("backpressure");
        random_ready = 1'b1;
        for (int k = 0; k < n_stress; k++) begin
            inst = alu_inst(1'(rand_bits(1)));
            send_inst(inst, rand_pc(), rand_bits(32), rand_bits(32));
        end
        end_test();

        start_test("illegal");
        random_ready = 1'b1;
        for (int k = 0; k < n_illegal; k++) begin
            inst = rand_bits(32);
            case (k % 4)
                0:       inst[6:0] = 7'b0000011;     // Load
                1:       inst[6:0] = 7'b0100011;     // Store
                2:       inst[6:0] = 7'b1110011;     // System
                default: inst[6:0] = 7'b0001111;     // Fence
            endcase
            send_inst(inst, rand_pc(), rand_bits(32), rand_bits(32));
        end
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
